//--- Bender.yml
package:
  name: bus_unit

sources:
  - source/bus_pkg.sv
  - source/bus_read_arbiter.sv
  - source/bus_write_channel.sv
  - source/bus_clint.sv
  - source/bus_top.sv
  - target: test
    files:
      - verif/axi_mem_model.sv
      - verif/bus_tb.sv

//--- list.f
source/bus_pkg.sv
source/bus_read_arbiter.sv
source/bus_write_channel.sv
source/bus_clint.sv
source/bus_top.sv
verif/axi_mem_model.sv
verif/bus_tb.sv

//--- source/bus_clint.sv
module bus_clint (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       clint_sel,
  input  logic [bus_pkg::xlen-1:0]   addr,
  output logic [bus_pkg::xlen-1:0]   clint_rdata,
  output logic                       clint_rvalid
);

  logic [63:0] mtime;
  logic        sel_q;
  logic        sel_rise;

  // free running, one tick per clock
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  assign sel_rise = clint_sel && !sel_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q        <= 1'b0;
      clint_rvalid <= 1'b0;
    end else begin
      sel_q        <= clint_sel;
      clint_rvalid <= sel_rise; // one pulse per request
    end
  end

  always_ff @(posedge clock) begin
    if (sel_rise) begin
      if (addr == bus_pkg::clint_addr_hi) begin
        clint_rdata <= mtime[63:32];
      end else begin
        clint_rdata <= mtime[31:0];
      end
    end
  end

endmodule

//--- source/bus_pkg.sv
package bus_pkg;

  localparam int xlen = 32;

  // mtime halves as seen by loads
  localparam logic [xlen-1:0] clint_addr_lo = 32'h0200_0048;
  localparam logic [xlen-1:0] clint_addr_hi = 32'h0200_004c;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [7:0]      len;
    logic [2:0]      size;
    logic [1:0]      burst;
    logic [3:0]      id;
  } axi_ar_t;

  typedef struct packed {
    logic [xlen-1:0] data;
    logic [1:0]      resp;
    logic            last;
    logic [3:0]      id;
  } axi_r_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [7:0]      len;
    logic [2:0]      size;
    logic [1:0]      burst;
    logic [3:0]      id;
  } axi_aw_t;

  typedef struct packed {
    logic [xlen-1:0] data;
    logic [3:0]      strb;
    logic            last;
  } axi_w_t;

  typedef struct packed {
    logic [1:0] resp;
    logic [3:0] id;
  } axi_b_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
  } ifu_req_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [7:0]      rstrb;
  } load_req_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
    logic [7:0]      wstrb;
  } store_req_t;

  // byte, half or word; odd strobes fall back to byte
  function automatic logic [2:0] size_from_strobe(input logic [7:0] strb);
    logic [2:0] size;
    case (strb)
      8'h01:   size = 3'd0;
      8'h03:   size = 3'd1;
      8'h0f:   size = 3'd2;
      default: size = 3'd0;
    endcase
    return size;
  endfunction

endpackage

//--- source/bus_read_arbiter.sv
module bus_read_arbiter (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush_pipeline,
  input  bus_pkg::ifu_req_t     ifu,
  input  logic                  ifu_arvalid,
  input  logic                  ifu_lock,
  input  logic                  ifu_ready,
  input  bus_pkg::load_req_t    load,
  input  logic                  lsu_arvalid,
  input  logic                  arready,
  input  logic                  rvalid,
  input  logic                  clint_rvalid,
  output bus_pkg::axi_ar_t      ar,
  output logic                  arvalid,
  output logic                  rready,
  output logic                  ifu_rvalid,
  output logic                  lsu_axi_rvalid,
  output logic                  bus_ifu_ready,
  output logic                  clint_sel
);

  typedef enum logic [2:0] {
    st_fetch_idle,
    st_fetch_data,
    st_load_idle,
    st_load_data,
    st_load_flushed
  } read_state_t;

  read_state_t state;
  logic        clint_hit;
  logic        fetch_go;
  logic        load_go;

  assign clint_hit = (load.addr == bus_pkg::clint_addr_lo) ||
                     (load.addr == bus_pkg::clint_addr_hi);

  // timer answers any held load to its addresses without AXI
  assign clint_sel = lsu_arvalid && clint_hit;

  assign fetch_go = (state == st_fetch_idle) && ifu_arvalid && ifu_ready;
  assign load_go  = (state == st_load_idle) && lsu_arvalid && !clint_hit;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_fetch_idle;
    end else begin
      case (state)
        st_fetch_idle: begin
          if (fetch_go) begin
            if (arready) state <= st_fetch_data;
          end else if (!ifu_lock && lsu_arvalid) begin
            state <= st_load_idle;
          end
        end
        st_fetch_data: begin
          if (rvalid) state <= st_fetch_idle;
        end
        st_load_idle: begin
          if (load_go) begin
            // AR stays up until accepted
            if (arready) state <= flush_pipeline ? st_load_flushed : st_load_data;
          end else if (clint_sel) begin
            if (clint_rvalid) state <= st_fetch_idle; // timer read done
          end else begin
            state <= st_fetch_idle; // back to the fetch side when nothing is held
          end
        end
        st_load_data: begin
          if (rvalid) begin
            state <= st_load_idle;
          end else if (flush_pipeline) begin
            state <= st_load_flushed;
          end
        end
        st_load_flushed: begin
          if (rvalid) state <= st_load_idle; // beat dropped
        end
        default: state <= st_fetch_idle;
      endcase
    end
  end

  assign arvalid = fetch_go || load_go;

  always_comb begin
    ar       = '0; // single beat, id 0
    ar.burst = 2'b01;
    if (state == st_load_idle) begin
      ar.addr = load.addr;
      ar.size = bus_pkg::size_from_strobe(load.rstrb);
    end else begin
      ar.addr = ifu.addr;
      ar.size = 3'd2; // fetch is always a word
    end
  end

  assign rready = (state == st_fetch_data) || (state == st_load_data) ||
                  (state == st_load_flushed);

  assign ifu_rvalid     = (state == st_fetch_data) && rvalid;
  assign lsu_axi_rvalid = (state == st_load_data) && rvalid;
  assign bus_ifu_ready  = (state == st_fetch_idle);

endmodule

//--- source/bus_top.sv
module bus_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush_pipeline,

  // fetch
  input  bus_pkg::ifu_req_t          ifu,
  input  logic                       ifu_arvalid,
  input  logic                       ifu_lock,
  input  logic                       ifu_ready,
  output logic [bus_pkg::xlen-1:0]   ifu_rdata,
  output logic                       ifu_rvalid,
  output logic                       bus_ifu_ready,

  // load
  input  bus_pkg::load_req_t         load,
  input  logic                       lsu_arvalid,
  output logic [bus_pkg::xlen-1:0]   lsu_rdata,
  output logic                       lsu_rvalid,

  // store
  input  bus_pkg::store_req_t        store,
  input  logic                       lsu_awvalid,
  input  logic                       lsu_wvalid,
  output logic                       lsu_wready,

  // AXI4 master
  output bus_pkg::axi_ar_t           ar,
  output logic                       arvalid,
  input  logic                       arready,
  input  bus_pkg::axi_r_t            r,
  input  logic                       rvalid,
  output logic                       rready,
  output bus_pkg::axi_aw_t           aw,
  output logic                       awvalid,
  input  logic                       awready,
  output bus_pkg::axi_w_t            w,
  output logic                       wvalid,
  input  logic                       wready,
  input  bus_pkg::axi_b_t            b,
  input  logic                       bvalid,
  output logic                       bready
);

  logic                     lsu_axi_rvalid;
  logic                     clint_sel;
  logic [bus_pkg::xlen-1:0] clint_rdata;
  logic                     clint_rvalid;

  bus_read_arbiter read_arb (
    .clock(clock),
    .reset(reset),
    .flush_pipeline(flush_pipeline),
    .ifu(ifu),
    .ifu_arvalid(ifu_arvalid),
    .ifu_lock(ifu_lock),
    .ifu_ready(ifu_ready),
    .load(load),
    .lsu_arvalid(lsu_arvalid),
    .arready(arready),
    .rvalid(rvalid),
    .clint_rvalid(clint_rvalid),
    .ar(ar),
    .arvalid(arvalid),
    .rready(rready),
    .ifu_rvalid(ifu_rvalid),
    .lsu_axi_rvalid(lsu_axi_rvalid),
    .bus_ifu_ready(bus_ifu_ready),
    .clint_sel(clint_sel)
  );

  bus_write_channel write_ch (
    .clock(clock),
    .reset(reset),
    .store(store),
    .lsu_awvalid(lsu_awvalid),
    .lsu_wvalid(lsu_wvalid),
    .awready(awready),
    .wready(wready),
    .bvalid(bvalid),
    .aw(aw),
    .awvalid(awvalid),
    .w(w),
    .wvalid(wvalid),
    .bready(bready),
    .lsu_wready(lsu_wready)
  );

  bus_clint clint (
    .clock(clock),
    .reset(reset),
    .clint_sel(clint_sel),
    .addr(load.addr),
    .clint_rdata(clint_rdata),
    .clint_rvalid(clint_rvalid)
  );

  assign ifu_rdata  = r.data;
  assign lsu_rvalid = lsu_axi_rvalid || clint_rvalid;
  assign lsu_rdata  = clint_sel ? clint_rdata : r.data; // timer or R lane

endmodule

//--- source/bus_write_channel.sv
module bus_write_channel (
  input  logic                  clock,
  input  logic                  reset,
  input  bus_pkg::store_req_t   store,
  input  logic                  lsu_awvalid,
  input  logic                  lsu_wvalid,
  input  logic                  awready,
  input  logic                  wready,
  input  logic                  bvalid,
  output bus_pkg::axi_aw_t      aw,
  output logic                  awvalid,
  output bus_pkg::axi_w_t       w,
  output logic                  wvalid,
  output logic                  bready,
  output logic                  lsu_wready
);

  typedef enum logic [1:0] {
    st_addr,
    st_data,
    st_resp
  } store_state_t;

  store_state_t state;
  logic [1:0]   offset;

  assign offset = store.addr[1:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_addr;
    end else begin
      case (state)
        st_addr: begin
          if (awvalid && awready) state <= st_data;
        end
        st_data: begin
          if (wvalid && wready) state <= st_resp;
        end
        st_resp: begin
          if (bvalid) state <= st_addr;
        end
        default: state <= st_addr;
      endcase
    end
  end

  assign awvalid = (state == st_addr) && lsu_awvalid;
  assign wvalid  = (state == st_data) && lsu_wvalid;
  assign bready  = (state == st_resp);

  // store ends on the B handshake
  assign lsu_wready = (state == st_resp) && bvalid;

  always_comb begin
    aw       = '0;
    aw.addr  = store.addr;
    aw.size  = bus_pkg::size_from_strobe(store.wstrb);
    aw.burst = 2'b01;
  end

  // move bytes onto their lanes
  assign w.data = store.data << {offset, 3'b000};
  assign w.strb = store.wstrb[3:0] << offset;
  assign w.last = wvalid; // one beat only

endmodule

//--- verif/axi_mem_model.sv
module axi_mem_model (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::axi_ar_t    ar,
  input  logic                arvalid,
  output logic                arready,
  output bus_pkg::axi_r_t     r,
  output logic                rvalid,
  input  logic                rready,
  input  bus_pkg::axi_aw_t    aw,
  input  logic                awvalid,
  output logic                awready,
  input  bus_pkg::axi_w_t     w,
  input  logic                wvalid,
  output logic                wready,
  output bus_pkg::axi_b_t     b,
  output logic                bvalid,
  input  logic                bready
);

  logic [31:0] mem [0:1023]; // 4 KB
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic        rd_busy;
  logic        aw_have;
  logic        w_have;
  int unsigned rd_cnt;
  int unsigned b_cnt;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {i[29:0], 2'b00} ^ 32'h5a5a0000;
    end
  end

  assign b = '0;

  always @(posedge clock) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      r       <= '0;
      rd_busy <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      aw_have <= 1'b0;
      w_have  <= 1'b0;
    end else begin
      // read side, response 1 to 3 cycles after AR
      if (arvalid && arready) begin
        rd_addr <= ar.addr;
        rd_busy <= 1'b1;
        rd_cnt  <= ($urandom % 3) + 1;
        arready <= 1'b0;
      end else if (rd_busy && !rvalid) begin
        if (rd_cnt == 1) begin
          rvalid <= 1'b1;
          r.data <= mem[rd_addr[11:2]];
          r.last <= 1'b1;
          r.resp <= 2'b00;
          r.id   <= 4'd0;
        end else begin
          rd_cnt <= rd_cnt - 1;
        end
      end else if (rvalid && rready) begin
        rvalid  <= 1'b0;
        rd_busy <= 1'b0;
      end else begin
        arready <= !rd_busy && ($urandom % 2 == 0);
      end

      // write side
      if (awvalid && awready) begin
        wr_addr <= aw.addr;
        aw_have <= 1'b1;
        awready <= 1'b0;
      end else begin
        awready <= !aw_have && ($urandom % 2 == 0);
      end
      if (wvalid && wready) begin
        for (int i = 0; i < 4; i++) begin
          if (w.strb[i]) mem[wr_addr[11:2]][8*i +: 8] <= w.data[8*i +: 8];
        end
        w_have <= 1'b1;
        wready <= 1'b0;
        b_cnt  <= ($urandom % 3) + 1;
      end else if (w_have && !bvalid) begin
        if (b_cnt == 1) bvalid <= 1'b1;
        else b_cnt <= b_cnt - 1;
      end else if (bvalid && bready) begin
        bvalid  <= 1'b0;
        aw_have <= 1'b0;
        w_have  <= 1'b0;
      end else begin
        wready <= aw_have && !w_have && ($urandom % 2 == 0);
      end
    end
  end

endmodule

//--- verif/bus_tb.sv
module bus_tb;

  localparam int n_requests = 26;
  localparam int n_stores   = 8;

  logic                     clock;
  logic                     reset;
  logic                     flush_pipeline;
  bus_pkg::ifu_req_t        ifu;
  logic                     ifu_arvalid;
  logic                     ifu_lock;
  logic                     ifu_ready;
  logic [31:0]              ifu_rdata;
  logic                     ifu_rvalid;
  logic                     bus_ifu_ready;
  bus_pkg::load_req_t       load;
  logic                     lsu_arvalid;
  logic [31:0]              lsu_rdata;
  logic                     lsu_rvalid;
  bus_pkg::store_req_t      store;
  logic                     lsu_awvalid;
  logic                     lsu_wvalid;
  logic                     lsu_wready;
  bus_pkg::axi_ar_t         ar;
  logic                     arvalid;
  logic                     arready;
  bus_pkg::axi_r_t          r;
  logic                     rvalid;
  logic                     rready;
  bus_pkg::axi_aw_t         aw;
  logic                     awvalid;
  logic                     awready;
  bus_pkg::axi_w_t          w;
  logic                     wvalid;
  logic                     wready;
  bus_pkg::axi_b_t          b;
  logic                     bvalid;
  logic                     bready;

  logic [31:0] shadow [0:1023];
  string       test_name;
  logic [31:0] exp_fetch;
  logic [31:0] exp_load;
  logic [2:0]  exp_arsize;
  logic [31:0] exp_wdata;
  logic [3:0]  exp_wstrb;
  logic [2:0]  exp_awsize;
  logic [31:0] first_lo;
  int unsigned first_cyc;
  int unsigned cyc;
  int unsigned wready_count;
  bit          timer_mode;
  bit          lo_check;
  bit          hi_check;
  bit          store_open;
  bit          flush_open;

  bus_top dut0 (.*);

  axi_mem_model mem0 (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cyc <= cyc + 1;
    if (lsu_wready) wready_count <= wready_count + 1;
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic fail_run(input string what);
    $display("ERROR %s: %s", test_name, what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic logic [2:0] strobe_size(input logic [7:0] strb);
    if (strb == 8'h0f) return 3'd2;
    if (strb == 8'h03) return 3'd1;
    return 3'd0;
  endfunction

  // reset and fetch, outputs are known from the first reset edge on
  assert property (@(posedge clock) cyc != 0 && (reset || $fell(reset)) |-> !arvalid &&
      !awvalid && !wvalid && !rready && !bready && !ifu_rvalid && !lsu_rvalid &&
      !lsu_wready && bus_ifu_ready)
    else fail_run("control output active during reset");
  assert property (@(posedge clock) disable iff (reset) ifu_rvalid |-> ifu_rdata == exp_fetch)
    else report_mismatch(test_name, exp_fetch, $sampled(ifu_rdata));
  assert property (@(posedge clock) disable iff (reset) bus_ifu_ready && !ifu_ready |-> !arvalid)
    else fail_run("arvalid while fetch side not ready");

  // loads
  assert property (@(posedge clock) disable iff (reset)
      arvalid && arready && !bus_ifu_ready |-> ar.size == exp_arsize)
    else report_mismatch(test_name, exp_arsize, $sampled(ar.size));
  assert property (@(posedge clock) disable iff (reset)
      lsu_rvalid && !timer_mode |-> lsu_rdata == exp_load)
    else report_mismatch(test_name, exp_load, $sampled(lsu_rdata));
  assert property (@(posedge clock) disable iff (reset)
      ifu_lock && lsu_arvalid |-> !(arvalid && !bus_ifu_ready))
    else fail_run("load AR issued while fetch lock held");

  // stores
  assert property (@(posedge clock) disable iff (reset) wvalid |-> w.data == exp_wdata)
    else report_mismatch(test_name, exp_wdata, $sampled(w.data));
  assert property (@(posedge clock) disable iff (reset) wvalid |-> w.strb == exp_wstrb)
    else report_mismatch(test_name, exp_wstrb, $sampled(w.strb));
  assert property (@(posedge clock) disable iff (reset) wvalid |-> w.last)
    else fail_run("wlast low with wvalid");
  assert property (@(posedge clock) disable iff (reset) awvalid |-> aw.size == exp_awsize)
    else report_mismatch(test_name, exp_awsize, $sampled(aw.size));
  assert property (@(posedge clock) disable iff (reset) lsu_wready |-> store_open)
    else fail_run("extra lsu_wready pulse");

  // timer
  assert property (@(posedge clock) disable iff (reset)
      $rose(lsu_arvalid) && timer_mode |-> !lsu_rvalid ##1 lsu_rvalid)
    else fail_run("timer read not answered after one cycle");
  assert property (@(posedge clock) disable iff (reset) timer_mode |-> !(arvalid && arready))
    else fail_run("AR handshake during timer read");
  assert property (@(posedge clock) disable iff (reset)
      lsu_rvalid && lo_check |-> (lsu_rdata - first_lo) >= (cyc - first_cyc))
    else report_mismatch(test_name, first_lo + ($sampled(cyc) - first_cyc),
                         $sampled(lsu_rdata));
  assert property (@(posedge clock) disable iff (reset) lsu_rvalid && hi_check |-> lsu_rdata == 0)
    else report_mismatch(test_name, 32'd0, $sampled(lsu_rdata));

  // flush
  assert property (@(posedge clock) disable iff (reset) lsu_rvalid |-> !flush_open)
    else fail_run("lsu_rvalid for a flushed load");
  assert property (@(posedge clock) disable iff (reset) flush_open && rvalid |-> rready)
    else fail_run("flushed R beat not accepted");

  task automatic fetch_word(input logic [31:0] addr, input int stall);
    test_name = "fetch";
    exp_fetch = shadow[addr[11:2]];
    @(posedge clock);
    ifu.addr    <= addr;
    ifu_arvalid <= 1'b1;
    ifu_ready   <= 1'b0;
    repeat (stall) @(posedge clock);
    ifu_ready <= 1'b1;
    @(posedge clock);
    while (!ifu_rvalid) @(posedge clock);
    ifu_arvalid <= 1'b0;
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [7:0] rstrb);
    test_name  = "load";
    exp_arsize = strobe_size(rstrb);
    exp_load   = shadow[addr[11:2]];
    @(posedge clock);
    load.addr   <= addr;
    load.rstrb  <= rstrb;
    lsu_arvalid <= 1'b1;
    @(posedge clock);
    while (!lsu_rvalid) @(posedge clock);
    lsu_arvalid <= 1'b0;
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [7:0] wstrb);
    int off;
    off        = addr[1:0];
    test_name  = "store";
    exp_awsize = strobe_size(wstrb);
    exp_wdata  = '0;
    exp_wstrb  = '0;
    for (int i = 0; i < 4; i++) begin
      if (i >= off) begin
        exp_wdata[8*i +: 8] = data[8*(i-off) +: 8];
        exp_wstrb[i]        = wstrb[i-off];
      end
    end
    store_open = 1'b1;
    @(posedge clock);
    store.addr  <= addr;
    store.data  <= data;
    store.wstrb <= wstrb;
    lsu_awvalid <= 1'b1;
    lsu_wvalid  <= 1'b1;
    @(posedge clock);
    while (!lsu_wready) @(posedge clock);
    store_open = 1'b0;
    lsu_awvalid <= 1'b0;
    lsu_wvalid  <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (exp_wstrb[i]) shadow[addr[11:2]][8*i +: 8] = exp_wdata[8*i +: 8];
    end
  endtask

  task automatic timer_read(input logic [31:0] addr);
    test_name = "timer";
    @(posedge clock);
    load.addr   <= addr;
    load.rstrb  <= 8'h0f;
    lsu_arvalid <= 1'b1;
    @(posedge clock);
    while (!lsu_rvalid) @(posedge clock);
    lsu_arvalid <= 1'b0;
  endtask

  task automatic flushed_load(input logic [31:0] addr);
    test_name  = "flush";
    exp_arsize = 3'd2;
    @(posedge clock);
    load.addr   <= addr;
    load.rstrb  <= 8'h0f;
    lsu_arvalid <= 1'b1;
    @(posedge clock);
    while (!(arvalid && arready && !bus_ifu_ready)) @(posedge clock);
    flush_open = 1'b1;
    flush_pipeline <= 1'b1;
    lsu_arvalid    <= 1'b0;
    @(posedge clock);
    flush_pipeline <= 1'b0;
    while (!(rvalid && rready)) @(posedge clock);
    flush_open = 1'b0;
  endtask

  initial begin
    #(n_requests * 200 * 4);
    $display("watchdog: requests did not complete in time");
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'he4e9a83a));
    for (int i = 0; i < 1024; i++) shadow[i] = {i[29:0], 2'b00} ^ 32'h5a5a0000;
    reset          = 1'b1;
    flush_pipeline = 1'b0;
    ifu            = '0;
    ifu_arvalid    = 1'b0;
    ifu_lock       = 1'b0;
    ifu_ready      = 1'b0;
    load           = '0;
    lsu_arvalid    = 1'b0;
    store          = '0;
    lsu_awvalid    = 1'b0;
    lsu_wvalid     = 1'b0;
    cyc            = 0;
    wready_count   = 0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);

    fetch_word(32'h0000_0000, 0);
    fetch_word(32'h0000_0040, 3);
    fetch_word(32'h0000_0ffc, 1);

    load_word(32'h0000_0200, 8'h01);
    load_word(32'h0000_0204, 8'h03);
    load_word(32'h0000_0208, 8'h0f);

    // fetch goes first and the load waits for the lock to drop
    test_name  = "lock";
    exp_fetch  = shadow[32'h0000_0300 >> 2];
    exp_load   = shadow[32'h0000_0304 >> 2];
    exp_arsize = 3'd2;
    @(posedge clock);
    ifu_lock    <= 1'b1;
    ifu.addr    <= 32'h0000_0300;
    ifu_arvalid <= 1'b1;
    ifu_ready   <= 1'b1;
    load.addr   <= 32'h0000_0304;
    load.rstrb  <= 8'h0f;
    lsu_arvalid <= 1'b1;
    @(posedge clock);
    while (!ifu_rvalid) @(posedge clock);
    ifu_arvalid <= 1'b0;
    repeat (5) @(posedge clock);
    ifu_lock <= 1'b0;
    while (!lsu_rvalid) @(posedge clock);
    lsu_arvalid <= 1'b0;

    store_word(32'h0000_0100, 32'h0000_00a1, 8'h01);
    store_word(32'h0000_0101, 32'h0000_00b2, 8'h01);
    store_word(32'h0000_0102, 32'h0000_00c3, 8'h01);
    store_word(32'h0000_0103, 32'h0000_00d4, 8'h01);
    store_word(32'h0000_0110, 32'h0000_1234, 8'h03);
    store_word(32'h0000_0112, 32'h0000_5678, 8'h03);
    store_word(32'h0000_0120, 32'hcafe_f00d, 8'h0f);
    load_word(32'h0000_0100, 8'h0f);
    load_word(32'h0000_0110, 8'h0f);
    load_word(32'h0000_0120, 8'h0f);

    // load and store in flight together
    fork
      store_word(32'h0000_0140, 32'h89ab_cdef, 8'h0f);
      load_word(32'h0000_0180, 8'h03);
    join
    load_word(32'h0000_0140, 8'h0f);

    timer_mode = 1'b1;
    timer_read(bus_pkg::clint_addr_lo);
    first_lo  = lsu_rdata;
    first_cyc = cyc;
    repeat (7) @(posedge clock);
    lo_check = 1'b1;
    timer_read(bus_pkg::clint_addr_lo);
    lo_check = 1'b0;
    hi_check = 1'b1;
    timer_read(bus_pkg::clint_addr_hi);
    hi_check   = 1'b0;
    timer_mode = 1'b0;

    flushed_load(32'h0000_0220);
    load_word(32'h0000_0224, 8'h0f);

    repeat (5) @(posedge clock);
    if (wready_count != n_stores) begin
      report_mismatch("store_count", n_stores, wready_count);
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule
